// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  single_cpu_pkg::alu_op_e         op,
    input  logic [single_cpu_pkg::xlen-1:0] a,
    input  logic [single_cpu_pkg::xlen-1:0] b,
    output logic [single_cpu_pkg::xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // Upper bits of b ignored for shifts
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            single_cpu_pkg::alu_add: begin
                result = a + b;
            end
            single_cpu_pkg::alu_sub: begin
                result = a - b;
            end
            single_cpu_pkg::alu_sll: begin
                result = a << shamt;
            end
            single_cpu_pkg::alu_slt: begin
                result = {{(single_cpu_pkg::xlen-1){1'b0}}, lt_signed};
            end
            single_cpu_pkg::alu_sltu: begin
                result = {{(single_cpu_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            single_cpu_pkg::alu_xor: begin
                result = a ^ b;
            end
            single_cpu_pkg::alu_srl: begin
                result = a >> shamt;
            end
            single_cpu_pkg::alu_sra: begin
                result = $unsigned($signed(a) >>> shamt); // Sign bit fills from the left
            end
            single_cpu_pkg::alu_or: begin
                result = a | b;
            end
            single_cpu_pkg::alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int depth = 64
) (
    input  logic                            CLK,
    input  logic                            we,
    input  logic [single_cpu_pkg::xlen-1:0] addr,
    input  logic [single_cpu_pkg::xlen-1:0] wdata,
    output logic [single_cpu_pkg::xlen-1:0] rdata
);

    localparam int aw = $clog2(depth);

    logic [single_cpu_pkg::xlen-1:0] mem [depth];
    logic [aw-1:0]                   idx;

    // Word index, upper address bits wrap
    assign idx = addr[aw+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

// File: inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  single_cpu_pkg::inst_u           inst,
    output single_cpu_pkg::ctrl_t           ctrl,
    output logic [single_cpu_pkg::xlen-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

    always_comb begin
        ctrl            = '0;
        ctrl.rs1        = inst.r.rs1;
        ctrl.rs2        = inst.r.rs2;
        ctrl.rd         = inst.r.rd;
        ctrl.alu_op     = single_cpu_pkg::alu_add;
        imm             = '0;

        case (opcode)
            single_cpu_pkg::op_reg: begin
                ctrl.reg_we = 1'b1;
                case (funct3)
                    single_cpu_pkg::f3_add: begin
                        ctrl.alu_op = (funct7 == single_cpu_pkg::f7_alt) ?
                                      single_cpu_pkg::alu_sub : single_cpu_pkg::alu_add;
                    end
                    single_cpu_pkg::f3_sll:  ctrl.alu_op = single_cpu_pkg::alu_sll;
                    single_cpu_pkg::f3_slt:  ctrl.alu_op = single_cpu_pkg::alu_slt;
                    single_cpu_pkg::f3_sltu: ctrl.alu_op = single_cpu_pkg::alu_sltu;
                    single_cpu_pkg::f3_xor:  ctrl.alu_op = single_cpu_pkg::alu_xor;
                    single_cpu_pkg::f3_sr: begin
                        ctrl.alu_op = (funct7 == single_cpu_pkg::f7_alt) ?
                                      single_cpu_pkg::alu_sra : single_cpu_pkg::alu_srl;
                    end
                    single_cpu_pkg::f3_or:   ctrl.alu_op = single_cpu_pkg::alu_or;
                    default:                 ctrl.alu_op = single_cpu_pkg::alu_and;
                endcase
                // Alternate funct7 only exists for sub and sra
                if (!(funct7 == single_cpu_pkg::f7_base ||
                      (funct7 == single_cpu_pkg::f7_alt &&
                       (funct3 == single_cpu_pkg::f3_add || funct3 == single_cpu_pkg::f3_sr)))) begin
                    ctrl.illegal = 1'b1;
                end
            end
            single_cpu_pkg::op_imm: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm = {{(single_cpu_pkg::xlen-12){inst.i.imm[11]}}, inst.i.imm};
                case (funct3)
                    single_cpu_pkg::f3_add:  ctrl.alu_op = single_cpu_pkg::alu_add;
                    single_cpu_pkg::f3_slt:  ctrl.alu_op = single_cpu_pkg::alu_slt;
                    single_cpu_pkg::f3_sltu: ctrl.alu_op = single_cpu_pkg::alu_sltu;
                    single_cpu_pkg::f3_xor:  ctrl.alu_op = single_cpu_pkg::alu_xor;
                    single_cpu_pkg::f3_or:   ctrl.alu_op = single_cpu_pkg::alu_or;
                    single_cpu_pkg::f3_and:  ctrl.alu_op = single_cpu_pkg::alu_and;
                    single_cpu_pkg::f3_sll: begin
                        ctrl.alu_op  = single_cpu_pkg::alu_sll;
                        imm          = {27'd0, inst.i.imm[4:0]}; // Shift distance only
                        ctrl.illegal = (funct7 != single_cpu_pkg::f7_base);
                    end
                    default: begin // srli and srai, kind from bit 30
                        ctrl.alu_op  = inst[30] ? single_cpu_pkg::alu_sra : single_cpu_pkg::alu_srl;
                        imm          = {27'd0, inst.i.imm[4:0]};
                        ctrl.illegal = (funct7 != single_cpu_pkg::f7_base) &&
                                       (funct7 != single_cpu_pkg::f7_alt);
                    end
                endcase
            end
            single_cpu_pkg::op_load: begin
                ctrl.reg_we     = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                imm = {{(single_cpu_pkg::xlen-12){inst.i.imm[11]}}, inst.i.imm};
                ctrl.illegal    = (funct3 != single_cpu_pkg::f3_word);
            end
            single_cpu_pkg::op_store: begin
                ctrl.mem_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.rd      = 5'd0; // rd field carries offset bits here
                imm = {{(single_cpu_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.illegal = (funct3 != single_cpu_pkg::f3_word);
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // Illegal words retire without side effects
        if (ctrl.illegal) begin
            ctrl.reg_we     = 1'b0;
            ctrl.mem_we     = 1'b0;
            ctrl.mem_to_reg = 1'b0;
            ctrl.rd         = 5'd0;
        end
    end

endmodule

// File: inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
    parameter int depth = 64
) (
    input  logic                                  CLK,
    input  logic                                  we,
    input  logic [$clog2(depth)-1:0]              waddr,
    input  logic [single_cpu_pkg::xlen-1:0]       wdata,
    input  logic [single_cpu_pkg::xlen-1:0]       raddr,
    output single_cpu_pkg::inst_u                 rdata
);

    logic [single_cpu_pkg::xlen-1:0] mem [depth];
    logic [single_cpu_pkg::xlen-3:0] word_idx;

    assign word_idx = raddr[single_cpu_pkg::xlen-1:2]; // Byte address to word index

    // Loading port, only used while the core is halted
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Out of range fetches give an all-zero word, opcode 0 is illegal
    always_comb begin
        if (word_idx < depth) begin
            rdata = mem[word_idx[$clog2(depth)-1:0]];
        end else begin
            rdata = '0;
        end
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic [4:0]                      rs1,
    input  logic [4:0]                      rs2,
    input  logic [4:0]                      rd,
    input  logic                            we,
    input  logic [single_cpu_pkg::xlen-1:0] wdata,
    output logic [single_cpu_pkg::xlen-1:0] rdata1,
    output logic [single_cpu_pkg::xlen-1:0] rdata2
);

    logic [single_cpu_pkg::xlen-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // Reads see the value before a same-cycle write
    always_comb begin
        if (rs1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

// File: single_cpu.f
single_cpu_pkg.sv
inst_mem.sv
register_file.sv
inst_decode.sv
alu.sv
data_mem.sv
single_cpu.sv
tb_single_cpu.sv

// File: single_cpu.sv
`timescale 1ns/1ps

module single_cpu #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [$clog2(imem_words)-1:0]   load_addr,
    input  logic [single_cpu_pkg::xlen-1:0] load_data,
    output single_cpu_pkg::retire_t         retire
);

    logic [single_cpu_pkg::xlen-1:0] pc;
    single_cpu_pkg::inst_u           inst;
    single_cpu_pkg::ctrl_t           ctrl;
    logic [single_cpu_pkg::xlen-1:0] imm;
    logic [single_cpu_pkg::xlen-1:0] rdata1;
    logic [single_cpu_pkg::xlen-1:0] rdata2;
    logic [single_cpu_pkg::xlen-1:0] alu_b;
    logic [single_cpu_pkg::xlen-1:0] alu_result;
    logic [single_cpu_pkg::xlen-1:0] mem_rdata;
    logic [single_cpu_pkg::xlen-1:0] wb_data;
    logic                            reg_we;
    logic                            mem_we;

    // Held at zero while halted
    always_ff @(posedge CLK) begin
        if (RST || !run) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    inst_mem #(
        .depth (imem_words)
    ) inst_mem_i (
        .CLK   (CLK),
        .we    (load_en),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (pc),
        .rdata (inst)
    );

    inst_decode inst_decode_i (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    assign reg_we = ctrl.reg_we & run; // No side effects while halted
    assign mem_we = ctrl.mem_we & run;

    register_file register_file_i (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ctrl.rd),
        .we     (reg_we),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = ctrl.use_imm ? imm : rdata2;

    alu alu_i (
        .op     (ctrl.alu_op),
        .a      (rdata1),
        .b      (alu_b),
        .result (alu_result)
    );

    data_mem #(
        .depth (dmem_words)
    ) data_mem_i (
        .CLK   (CLK),
        .we    (mem_we),
        .addr  (alu_result), // Effective address for lw and sw
        .wdata (rdata2),
        .rdata (mem_rdata)
    );

    assign wb_data = ctrl.mem_to_reg ? mem_rdata : alu_result;

    // One record per executed instruction, a cycle after its writes
    always_ff @(posedge CLK) begin
        retire.pc    <= pc;
        retire.rd    <= ctrl.rd;
        retire.wdata <= wb_data;
        retire.we    <= ctrl.reg_we;
        if (RST) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= run;
        end
    end

endmodule

// File: single_cpu_cases.txt
# Lines are test <name>, then i <instruction> <pc> <rd> <we> <wdata> in hex, then end
# The wdata column is only compared when we is 1
test reg_ops
i ff800093 00000000 01 1 fffffff8
i 00300113 00000004 02 1 00000003
i 002081b3 00000008 03 1 fffffffb
i 40208233 0000000c 04 1 fffffff5
i 002112b3 00000010 05 1 00000018
i 0020a333 00000014 06 1 00000001
i 0020b3b3 00000018 07 1 00000000
i 0020c433 0000001c 08 1 fffffffb
i 0020d4b3 00000020 09 1 1fffffff
i 4020d533 00000024 0a 1 ffffffff
i 0020e5b3 00000028 0b 1 fffffffb
i 0020f633 0000002c 0c 1 00000000
end
test imm_ops
i f9c00093 00000000 01 1 ffffff9c
i f9d0a113 00000004 02 1 00000001
i 0050b193 00000008 03 1 00000000
i fff0c213 0000000c 04 1 00000063
i 7f006293 00000010 05 1 000007f0
i 0ff0f313 00000014 06 1 0000009c
i 00429393 00000018 07 1 00007f00
i 01c0d413 0000001c 08 1 0000000f
i 4040d493 00000020 09 1 fffffff9
end
test memory
i 12300093 00000000 01 1 00000123
i 01000293 00000004 05 1 00000010
i 00102423 00000008 00 0 00000000
i fe52ae23 0000000c 00 0 00000000
i 00802183 00000010 03 1 00000123
i ffc2a203 00000014 04 1 00000010
i ff82a303 00000018 06 1 00000123
end
test x0_and_dependence
i 00500013 00000000 00 1 00000005
i 000000b3 00000004 01 1 00000000
i 00700113 00000008 02 1 00000007
i 00110113 0000000c 02 1 00000008
i 002101b3 00000010 03 1 00000010
i 402181b3 00000014 03 1 00000008
end
test sequencing
i 02a00093 00000000 01 1 0000002a
i ffffffff 00000004 00 0 00000000
i 020000b3 00000008 00 0 00000000
i 00108113 0000000c 02 1 0000002b
i 002081b3 00000010 03 1 00000055
end

// File: single_cpu_pkg.sv
package single_cpu_pkg;

    parameter int xlen = 32;

    // Major opcodes of the kept subset
    parameter logic [6:0] op_reg   = 7'b0110011;
    parameter logic [6:0] op_imm   = 7'b0010011;
    parameter logic [6:0] op_load  = 7'b0000011;
    parameter logic [6:0] op_store = 7'b0100011;

    // funct3 codes for arithmetic and logic
    parameter logic [2:0] f3_add  = 3'b000; // add, sub, addi
    parameter logic [2:0] f3_sll  = 3'b001;
    parameter logic [2:0] f3_slt  = 3'b010;
    parameter logic [2:0] f3_sltu = 3'b011;
    parameter logic [2:0] f3_xor  = 3'b100;
    parameter logic [2:0] f3_sr   = 3'b101; // srl and sra
    parameter logic [2:0] f3_or   = 3'b110;
    parameter logic [2:0] f3_and  = 3'b111;
    parameter logic [2:0] f3_word = 3'b010; // lw and sw

    // funct7 codes
    parameter logic [6:0] f7_base = 7'b0000000;
    parameter logic [6:0] f7_alt  = 7'b0100000; // sub and sra

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // Same instruction word seen as R-type or I-type
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        alu_op_e    alu_op;
        logic       use_imm;    // ALU b from immediate
        logic       reg_we;
        logic       mem_we;
        logic       mem_to_reg; // Writeback from data memory
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
        logic            we;
    } retire_t;

endpackage

// File: tb_single_cpu.sv
`timescale 1ns/1ps

module tb_single_cpu;

    localparam int imem_words    = 64;
    localparam int dmem_words    = 64;
    localparam int margin_cycles = 100; // Reset, load and drain of one test

    logic                    CLK = 1'b0;
    logic                    RST;
    logic                    run;
    logic                    load_en;
    logic [5:0]              load_addr;
    logic [31:0]             load_data;
    single_cpu_pkg::retire_t retire;

    // Test table filled from the cases file
    string       names [$];
    int          first [$]; // Index of the first line of each test
    int          count [$];
    logic [31:0] inst_q [$];
    logic [31:0] pc_q [$];
    logic [4:0]  rd_q [$];
    logic        we_q [$];
    logic [31:0] wdata_q [$];

    int watchdog_cycles = 0;
    int passed = 0;
    int failed = 0;
    int errors = 0;

    single_cpu #(
        .imem_words (imem_words),
        .dmem_words (dmem_words)
    ) single_cpu_i (
        .CLK       (CLK),
        .RST       (RST),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .retire    (retire)
    );

    always #4 CLK = ~CLK;

    task automatic read_cases();
        int          fd;
        int          code;
        string       line;
        string       tag;
        string       name;
        logic [31:0] v_inst;
        logic [31:0] v_pc;
        logic [31:0] v_rd;
        logic [31:0] v_we;
        logic [31:0] v_wdata;
        fd = $fopen("single_cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open single_cpu_cases.txt");
            failed++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                code = $sscanf(line, "%s", tag);
                if (code < 1 || line[0] == "#") begin
                    // Blank or comment line
                end else if (tag == "test") begin
                    code = $sscanf(line, "%s %s", tag, name);
                    names.push_back(name);
                    first.push_back(pc_q.size());
                    count.push_back(0);
                end else if (tag == "i" && names.size() > 0) begin
                    code = $sscanf(line, "%s %h %h %h %h %h", tag, v_inst, v_pc, v_rd, v_we,
                                   v_wdata);
                    inst_q.push_back(v_inst);
                    pc_q.push_back(v_pc);
                    rd_q.push_back(v_rd[4:0]);
                    we_q.push_back(v_we[0]);
                    wdata_q.push_back(v_wdata);
                    count[count.size()-1] = count[count.size()-1] + 1;
                end else if (tag != "end") begin
                    $display("Unrecognized line in cases file: %s", line);
                    failed++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: retire.%s got %h expected %h", test, field, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int   base;
        int   n;
        int   waited;
        logic missing;
        base    = first[t];
        n       = count[t];
        errors  = 0;
        missing = 1'b0;
        @(negedge CLK);
        RST     = 1'b1;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (2) @(negedge CLK);
        RST = 1'b0;
        // Program goes in while the core is halted
        for (int k = 0; k < n; k++) begin
            load_en   = 1'b1;
            load_addr = k[5:0];
            load_data = inst_q[base+k];
            @(negedge CLK);
            assert (retire.valid === 1'b0) else begin
                $display("Test %s: retire record valid while the core is halted", names[t]);
                errors++;
            end
        end
        load_en = 1'b0;
        run     = 1'b1;
        for (int k = 0; k < n && !missing; k++) begin
            waited = 0;
            @(negedge CLK);
            while (retire.valid !== 1'b1 && waited < 4) begin
                @(negedge CLK);
                waited++;
            end
            assert (retire.valid === 1'b1) else begin
                $display("Test %s: no retire record for pc %h", names[t], pc_q[base+k]);
                errors++;
                missing = 1'b1;
            end
            if (!missing) begin
                // One record per cycle while running
                assert (waited == 0) else begin
                    $display("Test %s: retire record for pc %h came %0d cycles late",
                             names[t], pc_q[base+k], waited);
                    errors++;
                end
                compare_field(names[t], "pc", retire.pc, pc_q[base+k]);
                compare_field(names[t], "rd", {27'd0, retire.rd}, {27'd0, rd_q[base+k]});
                compare_field(names[t], "we", {31'd0, retire.we}, {31'd0, we_q[base+k]});
                if (we_q[base+k]) begin
                    compare_field(names[t], "wdata", retire.wdata, wdata_q[base+k]);
                end
            end
        end
        run = 1'b0; // Halt right after the last expected record
        @(negedge CLK);
        assert (retire.valid === 1'b0) else begin
            $display("Test %s: extra retire record after the last expected one", names[t]);
            errors++;
        end
        if (errors == 0) begin
            $display("Test %s: pass", names[t]);
            passed++;
        end else begin
            $display("Test %s: fail with %0d errors", names[t], errors);
            failed++;
        end
    endtask

    initial begin
        RST       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_cases();
        watchdog_cycles = pc_q.size() * 4 + (names.size() + 1) * margin_cycles;
        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && names.size() > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog armed once the cases file has been read
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge CLK);
        $display("Timeout after %0d cycles, the run did not complete", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
